/* dv/core_testdata.hex */
// Word 0: program length in the upper half, store count in the lower half
// Then program words from 0x0001_0000, then expected store address and data pairs
00300011
// 0-7: addi, addi, lui, add, sub, and, or, xor
06400093 FF900113 123451B7 00208233 402082B3 0020F333 0011E3B3 0021C433
// 8-15: slt, slt, stores of the ALU results
001124B3 0020A533 00102023 00302223 00402423 00502623 00602823 00702A23
// 16-23: stores, then the forwarding chain
00802C23 00902E23 02A02023 02202223 00500593 00B58633 00300693 00D60733
// 24-31: chain stores, lw then dependent add
00100793 00200813 00E708B3 03102423 02E02623 02C02823 00802903 001909B3
// 32-39: lw then sw of the loaded value, beq taken, bne not taken, bne taken
03302A23 01802A03 03402C23 00108463 02102E23 00109463 02902E23 00209663
// 40-47: flushed stores, beq not taken, jal x21, flushed stores, link store, loop
04102023 04102223 00208463 00C00AEF 04102023 04102223 05502023 0000006F
// Expected stores
00000000 00000064
00000004 12345000
00000008 0000005D
0000000C 0000006B
00000010 00000060
00000014 12345064
00000018 EDCBAFF9
0000001C 00000001
00000020 00000000
00000024 FFFFFFF9
00000028 0000001A
0000002C 0000000D
00000030 0000000A
00000034 000000C1
00000038 EDCBAFF9
0000003C 00000001
00000040 000100B0

/* flist.f */
source/rv_pkg.sv
source/stage_ifs.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/core_top.sv
dv/core_assertions.sv
dv/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int          TDATA_WORDS  = 128;
    localparam int          DMEM_WORDS   = 64;
    localparam int          DRAIN_CYCLES = 10;
    localparam logic [31:0] IMEM_BASE    = 32'h0001_0000;
    localparam logic [31:0] NOP          = 32'h0000_0013;   // addi x0, x0, 0

    logic        clk;
    logic        reset;
    logic [31:0] iad;
    logic [31:0] idt;
    logic [31:0] dad;
    logic [31:0] dwdata;
    logic        dwrite;
    logic        dread;
    logic [31:0] drdata;

    logic [31:0] tdata [TDATA_WORDS];   // Header, program, expected stores
    logic [31:0] dmem [DMEM_WORDS];
    int prog_len;
    int store_total;
    int cycle_limit;
    int cycle_count;
    int error_count;
    int store_count  = 0;
    int store_errors = 0;
    logic timed_out;

    core_top dut0 (
        .clk(clk),
        .reset(reset),
        .iad(iad),
        .idt(idt),
        .dad(dad),
        .dwdata(dwdata),
        .dwrite(dwrite),
        .dread(dread),
        .drdata(drdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        int index;
        index = int'((addr - IMEM_BASE) >> 2);
        if ($isunknown(addr) || addr < IMEM_BASE || index >= prog_len) begin
            return NOP;
        end
        return tdata[7'(index + 1)];
    endfunction

    // Instruction memory answers in the same cycle
    always_comb idt = program_word(iad);

    // Read data only while the core asks for it
    assign drdata = dread ? dmem[dad[7:2]] : 'x;

    always @(posedge clk) begin
        if (dwrite) begin
            dmem[dad[7:2]] <= dwdata;
        end
    end

    // Stores checked mid-cycle in program order
    always @(negedge clk) begin
        int          slot;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        if (dwrite) begin
            if (store_count >= store_total) begin
                $display("Unexpected extra store to address %h at time %0t", dad, $time);
                store_errors++;
            end else begin
                slot     = 1 + prog_len + 2 * store_count;
                exp_addr = tdata[7'(slot)];
                exp_data = tdata[7'(slot + 1)];
                if (dad !== exp_addr) begin
                    $display("FAILED %0t: store %0d address %h, expected %h",
                             $time, store_count, dad, exp_addr);
                    store_errors++;
                end
                if (dwdata !== exp_data) begin
                    $display("FAILED %0t: store %0d data %h, expected %h",
                             $time, store_count, dwdata, exp_data);
                    store_errors++;
                end
            end
            store_count++;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        error_count = 0;
        cycle_count = 0;
        timed_out   = 1'b0;
        $readmemh("dv/core_testdata.hex", tdata);
        prog_len    = int'(tdata[0][31:16]);
        store_total = int'(tdata[0][15:0]);
        cycle_limit = 4 * prog_len + 200;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[6'(i)] = 32'hDA7A_0000 | 32'(i * 4);   // Byte address in the low half
        end

        repeat (16) @(negedge clk);
        reset = 1'b0;

        // PC still holds its reset value in this cycle
        if (iad !== 32'h0001_0000) begin
            $display("FAILED %0t: iad %h after reset, expected 00010000", $time, iad);
            error_count++;
        end

        while (store_count < store_total && cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        if (store_count < store_total) begin
            timed_out = 1'b1;
            $display("Timed out after %0d cycles with only %0d of %0d stores seen",
                     cycle_count, store_count, store_total);
            error_count++;
        end

        repeat (DRAIN_CYCLES) @(posedge clk);   // Catch late extra stores
        if (!timed_out && store_count != store_total) begin
            $display("Saw %0d stores but the program should make %0d",
                     store_count, store_total);
            error_count++;
        end

        $display("Errors: %0d, stores: %0d of %0d", error_count + store_errors,
                 store_count, store_total);
        if (error_count + store_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dv/core_assertions.sv */
`timescale 1ns/1ps

module core_assertions (
    input logic        clk,
    input logic        reset,
    input logic [31:0] iad,
    input logic        dwrite,
    input logic        dread
);

    // Single MEM stage never raises both strobes
    no_read_with_write: assert property (@(posedge clk) disable iff (reset)
        !(dwrite && dread))
        else $error("dwrite and dread are high in the same cycle");

    strobes_low_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !dwrite && !dread)
        else $error("Data strobe active while reset is high");

    iad_word_aligned: assert property (@(posedge clk) disable iff (reset)
        iad[1:0] == 2'b00)
        else $error("iad %h is not word aligned", iad);

endmodule

bind core_top core_assertions core_assertions_inst (
    .clk(clk),
    .reset(reset),
    .iad(iad),
    .dwrite(dwrite),
    .dread(dread)
);

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = rv_pkg::RESET_PC
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::XLEN-1:0] iad,
    input  logic [rv_pkg::XLEN-1:0] idt,
    output logic [rv_pkg::XLEN-1:0] dad,
    output logic [rv_pkg::XLEN-1:0] dwdata,
    output logic                    dwrite,
    output logic                    dread,
    input  logic [rv_pkg::XLEN-1:0] drdata
);
    import rv_pkg::*;

    logic             stall;
    logic             flush;
    logic             redirect;
    logic [XLEN-1:0]  redirect_pc;
    logic [REG_W-1:0] mem_fwd_rd;
    logic             mem_fwd_en;
    logic [XLEN-1:0]  mem_fwd_data;

    if_id_bus  ifid ();
    id_ex_bus  idex ();
    ex_mem_bus exmem ();
    wb_bus     wb ();

    fetch_stage #(
        .RESET_ADDR(RESET_ADDR)
    ) fetch_inst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .iad(iad),
        .idt(idt),
        .ifid(ifid.source)
    );

    decode_stage decode_inst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .ifid(ifid.sink),
        .idex(idex.source),
        .wb(wb.sink)
    );

    execute_stage execute_inst (
        .clk(clk),
        .reset(reset),
        .idex(idex.sink),
        .exmem(exmem.source),
        .mem_fwd_rd(mem_fwd_rd),
        .mem_fwd_en(mem_fwd_en),
        .mem_fwd_data(mem_fwd_data),
        .wb(wb.sink),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    memory_stage memory_inst (
        .clk(clk),
        .reset(reset),
        .exmem(exmem.sink),
        .dad(dad),
        .dwdata(dwdata),
        .dwrite(dwrite),
        .dread(dread),
        .drdata(drdata),
        .mem_fwd_rd(mem_fwd_rd),
        .mem_fwd_en(mem_fwd_en),
        .mem_fwd_data(mem_fwd_data),
        .wb(wb.source)
    );

    hazard_unit hazard_inst (
        .idex_opcode(idex.opcode),
        .idex_rd(idex.rd),
        .ifid_ir(ifid.ir),
        .ifid_valid(ifid.valid),
        .redirect(redirect),
        .stall(stall),
        .flush(flush)
    );

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::opcode_t          idex_opcode,
    input  logic [rv_pkg::REG_W-1:0] idex_rd,
    input  logic [31:0]              ifid_ir,
    input  logic                     ifid_valid,
    input  logic                     redirect,
    output logic                     stall,
    output logic                     flush
);
    import rv_pkg::*;

    opcode_t id_op;
    logic    uses_rs1;
    logic    uses_rs2;
    logic    rd_match;

    assign id_op    = opcode_t'(ifid_ir[6:0]);
    assign uses_rs1 = id_op != LUI && id_op != JAL;
    assign uses_rs2 = id_op == OP || id_op == STORE || id_op == BRANCH;

    assign rd_match = (uses_rs1 && ifid_ir[19:15] == idex_rd) ||
                      (uses_rs2 && ifid_ir[24:20] == idex_rd);

    // Younger two instructions are dropped on a redirect
    assign flush = redirect;

    // Load result reaches execute one cycle too late
    assign stall = !redirect && ifid_valid && idex_opcode == LOAD &&
                   idex_rd != '0 && rd_match;

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                     clk,
    input  logic                     reset,
    ex_mem_bus.sink                  exmem,
    output logic [rv_pkg::XLEN-1:0]  dad,
    output logic [rv_pkg::XLEN-1:0]  dwdata,
    output logic                     dwrite,
    output logic                     dread,
    input  logic [rv_pkg::XLEN-1:0]  drdata,
    output logic [rv_pkg::REG_W-1:0] mem_fwd_rd,
    output logic                     mem_fwd_en,
    output logic [rv_pkg::XLEN-1:0]  mem_fwd_data,
    wb_bus.source                    wb
);
    import rv_pkg::*;

    logic [XLEN-1:0] wb_data;

    assign dad    = exmem.alu_result;
    assign dwdata = exmem.store_data;
    assign dwrite = exmem.valid && exmem.opcode == STORE;   // Single-cycle strobe
    assign dread  = exmem.valid && exmem.opcode == LOAD;

    always_comb begin
        case (exmem.wb_sel)
            WB_MEM:  wb_data = drdata;
            WB_PC4:  wb_data = exmem.pc4;
            default: wb_data = exmem.alu_result;
        endcase
    end

    // Loads are covered by the load-use stall
    assign mem_fwd_rd   = exmem.rd;
    assign mem_fwd_en   = exmem.reg_write && exmem.rd != '0 && exmem.wb_sel != WB_MEM;
    assign mem_fwd_data = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.reg_write <= 1'b0;
        end else begin
            wb.reg_write <= exmem.valid && exmem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd     <= exmem.rd;
        wb.result <= wb_data;
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                     clk,
    input  logic                     reset,
    id_ex_bus.sink                   idex,
    ex_mem_bus.source                exmem,
    input  logic [rv_pkg::REG_W-1:0] mem_fwd_rd,
    input  logic                     mem_fwd_en,
    input  logic [rv_pkg::XLEN-1:0]  mem_fwd_data,
    wb_bus.sink                      wb,
    output logic                     redirect,
    output logic [rv_pkg::XLEN-1:0]  redirect_pc
);
    import rv_pkg::*;

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_y;
    logic            taken;

    // EX/MEM has priority over MEM/WB
    function automatic logic [XLEN-1:0] fwd(input logic [REG_W-1:0] rs,
                                            input logic [XLEN-1:0] rf_data);
        if (rs == '0) return rf_data;
        if (mem_fwd_en && mem_fwd_rd == rs) return mem_fwd_data;
        if (wb.reg_write && wb.rd == rs) return wb.result;
        return rf_data;
    endfunction

    always_comb begin
        rs1_fwd = fwd(idex.rs1, idex.rs1_data);
        rs2_fwd = fwd(idex.rs2, idex.rs2_data);
    end

    assign op_b = (idex.opcode == OP || idex.opcode == BRANCH) ? rs2_fwd : idex.imm;

    always_comb begin
        case (idex.alu_op)
            ALU_SUB:    alu_y = rs1_fwd - op_b;
            ALU_AND:    alu_y = rs1_fwd & op_b;
            ALU_OR:     alu_y = rs1_fwd | op_b;
            ALU_XOR:    alu_y = rs1_fwd ^ op_b;
            ALU_SLT:    alu_y = XLEN'($signed(rs1_fwd) < $signed(op_b));
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = rs1_fwd + op_b;
        endcase
    end

    assign taken = (idex.alu_op == ALU_SUB) ? (rs1_fwd == rs2_fwd) : (rs1_fwd != rs2_fwd);
    assign redirect = idex.valid &&
                      ((idex.opcode == BRANCH && taken) || idex.opcode == JAL);
    assign redirect_pc = idex.pc + idex.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            exmem.valid     <= 1'b0;
            exmem.reg_write <= 1'b0;
        end else begin
            exmem.valid     <= idex.valid;
            exmem.reg_write <= idex.valid && idex.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        exmem.pc4        <= idex.pc4;
        exmem.alu_result <= alu_y;
        exmem.store_data <= rs2_fwd;
        exmem.rd         <= idex.rd;
        exmem.opcode     <= idex.opcode;
        exmem.wb_sel     <= idex.wb_sel;
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    if_id_bus.sink   ifid,
    id_ex_bus.source idex,
    wb_bus.sink      wb
);
    import rv_pkg::*;

    logic [XLEN-1:0]  regs [32];
    opcode_t          op;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [2:0]       funct3;
    alu_op_t          alu_op;
    wb_sel_t          wb_sel;
    logic             reg_write;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;

    assign op     = opcode_t'(ifid.ir[6:0]);
    assign rs1    = ifid.ir[19:15];
    assign rs2    = ifid.ir[24:20];
    assign funct3 = ifid.ir[14:12];

    always_comb begin
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        reg_write = 1'b0;
        imm       = '0;
        case (op)
            OP: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ifid.ir[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_IMM: begin
                reg_write = 1'b1;
                imm = {{20{ifid.ir[31]}}, ifid.ir[31:20]};
            end
            LUI: begin
                reg_write = 1'b1;
                alu_op = ALU_PASS_B;
                imm = {ifid.ir[31:12], 12'b0};
            end
            LOAD: begin
                reg_write = 1'b1;
                wb_sel = WB_MEM;
                imm = {{20{ifid.ir[31]}}, ifid.ir[31:20]};
            end
            STORE: imm = {{20{ifid.ir[31]}}, ifid.ir[31:25], ifid.ir[11:7]};
            BRANCH: begin
                // Execute reads SUB as BEQ and XOR as BNE
                alu_op = funct3[0] ? ALU_XOR : ALU_SUB;
                imm = {{19{ifid.ir[31]}}, ifid.ir[31], ifid.ir[7], ifid.ir[30:25],
                       ifid.ir[11:8], 1'b0};
            end
            JAL: begin
                reg_write = 1'b1;
                wb_sel = WB_PC4;
                imm = {{11{ifid.ir[31]}}, ifid.ir[31], ifid.ir[19:12], ifid.ir[20],
                       ifid.ir[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Same-cycle write is visible to the read
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb.reg_write && wb.rd == rs1) ? wb.result : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb.reg_write && wb.rd == rs2) ? wb.result : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset || stall || flush || !ifid.valid) begin
            idex.valid     <= 1'b0;   // Bubble
            idex.reg_write <= 1'b0;
            idex.opcode    <= OP_IMM;
        end else begin
            idex.valid     <= 1'b1;
            idex.reg_write <= reg_write;
            idex.opcode    <= op;
        end
    end

    always_ff @(posedge clk) begin
        idex.pc       <= ifid.pc;
        idex.pc4      <= ifid.pc4;
        idex.rs1_data <= rs1_data;
        idex.rs2_data <= rs2_data;
        idex.rs1      <= rs1;
        idex.rs2      <= rs2;
        idex.rd       <= ifid.ir[11:7];
        idex.imm      <= imm;
        idex.alu_op   <= alu_op;
        idex.wb_sel   <= wb_sel;
    end

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = rv_pkg::RESET_PC
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    redirect,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic [rv_pkg::XLEN-1:0] iad,
    input  logic [rv_pkg::XLEN-1:0] idt,
    if_id_bus.source                ifid
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;

    assign pc4 = pc + XLEN'(4);
    assign iad = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_ADDR;
        end else if (redirect) begin
            pc <= redirect_pc;  // Taken branch or JAL from execute
        end else if (!stall) begin
            pc <= pc4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ifid.valid <= 1'b0;
        end else if (!stall) begin
            ifid.valid <= 1'b1;
        end
    end

    // Held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid.pc  <= pc;
            ifid.pc4 <= pc4;
            ifid.ir  <= idt;
        end
    end

endmodule

/* source/stage_ifs.sv */
`timescale 1ns/1ps

interface if_id_bus;
    import rv_pkg::*;

    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;
    logic [XLEN-1:0] ir;

    modport source (output valid, pc, pc4, ir);
    modport sink (input valid, pc, pc4, ir);
endinterface

interface id_ex_bus;
    import rv_pkg::*;

    logic             valid;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  pc4;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  imm;
    opcode_t          opcode;
    alu_op_t          alu_op;
    wb_sel_t          wb_sel;
    logic             reg_write;

    modport source (output valid, pc, pc4, rs1_data, rs2_data, rs1, rs2, rd, imm,
                    opcode, alu_op, wb_sel, reg_write);
    modport sink (input valid, pc, pc4, rs1_data, rs2_data, rs1, rs2, rd, imm,
                  opcode, alu_op, wb_sel, reg_write);
endinterface

interface ex_mem_bus;
    import rv_pkg::*;

    logic             valid;
    logic [XLEN-1:0]  pc4;
    logic [XLEN-1:0]  alu_result;
    logic [XLEN-1:0]  store_data;
    logic [REG_W-1:0] rd;
    opcode_t          opcode;
    wb_sel_t          wb_sel;
    logic             reg_write;

    modport source (output valid, pc4, alu_result, store_data, rd, opcode, wb_sel, reg_write);
    modport sink (input valid, pc4, alu_result, store_data, rd, opcode, wb_sel, reg_write);
endinterface

// Register file write port and forwarding source
interface wb_bus;
    import rv_pkg::*;

    logic             reg_write;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  result;

    modport source (output reg_write, rd, result);
    modport sink (input reg_write, rd, result);
endinterface

/* source/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;   // Register index width

    localparam logic [XLEN-1:0] RESET_PC = 32'h0001_0000;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

endpackage
